// File: flist.f
+incdir+logic
logic/mips_pkg.sv
logic/control_unit.sv
logic/reg_file.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/mips_core_top.sv
verif/tb_mips_core.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# pass only if the simulation prints the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f \
    --top-module tb_mips_core -o tb_mips_core || exit 1

./obj_dir/tb_mips_core | tee /dev/stderr | grep -F "ALL CHECKS PASSED" > /dev/null \
    && echo "run.sh: simulation passed" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: verif/tb_mips_core.sv
`default_nettype none

`include "mips_consts.svh"

module tb_mips_core;

    localparam int unsigned SEED      = 32'h222048e6;
    localparam int          NUM_INSTR = 400;

    logic                   i_clk;
    logic                   i_rst;
    logic                   i_step;
    logic [`MIPS_NB-1:0]    i_instruction;
    logic [`MIPS_REGS-1:0]  i_tx_dir_debug;
    logic [`MIPS_NB-1:0]    o_data_tx_debug;
    logic                   o_wb_valid;
    logic [`MIPS_REGS-1:0]  o_wb_dir;
    logic [`MIPS_NB-1:0]    o_wb_data;
    logic                   o_illegal;

    // one outstanding result with the negedge count when it is due
    typedef struct packed {
        logic                   is_illegal;
        logic [`MIPS_REGS-1:0]  dir;
        logic [`MIPS_NB-1:0]    data;
        int                     due;
    } expect_t;

    expect_t             exp_q[$];
    logic [`MIPS_NB-1:0] model_regs [`MIPS_NREGS];
    int                  ncyc;
    int                  wb_errs;
    int                  ill_errs;
    int                  reg_errs;
    int                  seq_errs;

    mips_core_top uut (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_step          (i_step),
        .i_instruction   (i_instruction),
        .i_tx_dir_debug  (i_tx_dir_debug),
        .o_data_tx_debug (o_data_tx_debug),
        .o_wb_valid      (o_wb_valid),
        .o_wb_dir        (o_wb_dir),
        .o_wb_data       (o_wb_data),
        .o_illegal       (o_illegal)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    task automatic check_wb(input logic [4:0] dir, input logic [31:0] data,
                            input logic [4:0] exp_dir, input logic [31:0] exp_data);
        if (dir !== exp_dir || data !== exp_data) begin
            $display("Mismatch at %0t: writeback r%0d = %h, expected r%0d = %h",
                     $time, dir, data, exp_dir, exp_data);
            wb_errs++;
        end
    endtask

    task automatic check_illegal(input logic flag, input logic exp_flag);
        if (flag !== exp_flag) begin
            $display("Mismatch at %0t: illegal flag %b, expected %b", $time, flag, exp_flag);
            ill_errs++;
        end
    endtask

    task automatic check_reg(input logic [4:0] addr, input logic [31:0] value,
                             input logic [31:0] exp_value);
        if (value !== exp_value) begin
            $display("Mismatch at %0t: debug read r%0d = %h, expected %h",
                     $time, addr, value, exp_value);
            reg_errs++;
        end
    endtask

    // random word with register fields in r0..r7 so hazards are common
    function automatic logic [31:0] rand_instr();
        int          kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sh;
        logic [15:0] imm;
        logic [5:0]  op;
        logic [5:0]  fn;
        kind = $urandom_range(0, 16);
        rs   = 5'($urandom_range(0, 7));
        rt   = 5'($urandom_range(0, 7));
        rd   = 5'($urandom_range(0, 7));
        sh   = 5'($urandom_range(0, 31));
        imm  = 16'($urandom);
        op   = mips_pkg::OP_SPECIAL;
        fn   = mips_pkg::FN_ADDU;
        case (kind)
            0:  fn = mips_pkg::FN_ADDU;
            1:  fn = mips_pkg::FN_SUBU;
            2:  fn = mips_pkg::FN_AND;
            3:  fn = mips_pkg::FN_OR;
            4:  fn = mips_pkg::FN_XOR;
            5:  fn = mips_pkg::FN_NOR;
            6:  fn = mips_pkg::FN_SLT;
            7:  fn = mips_pkg::FN_SLL;
            8:  fn = mips_pkg::FN_SRL;
            9:  op = mips_pkg::OP_ADDIU;
            10: op = mips_pkg::OP_SLTI;
            11: op = mips_pkg::OP_ANDI;
            12: op = mips_pkg::OP_ORI;
            13: op = mips_pkg::OP_XORI;
            14: op = mips_pkg::OP_LUI;
            // nothing from 0x10 up is a supported opcode
            15: op = 6'($urandom_range(16, 63));
            // same for functs 0x30 and above
            default: fn = 6'($urandom_range(48, 63));
        endcase
        if (op == mips_pkg::OP_SPECIAL) begin
            return {op, rs, rt, rd, sh, fn};
        end
        return {op, rs, rt, imm};
    endfunction

    // reference model in program order updating model_regs at issue
    task automatic model_step(input logic [31:0] instr, output logic has_out,
                              output expect_t e);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  dest;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] res;
        logic        legal;
        op    = instr[31:26];
        fn    = instr[5:0];
        a     = model_regs[instr[25:21]];
        b     = model_regs[instr[20:16]];
        simm  = {{16{instr[15]}}, instr[15:0]};
        zimm  = {16'h0000, instr[15:0]};
        dest  = instr[20:16];
        res   = '0;
        legal = 1'b1;
        case (op)
            mips_pkg::OP_SPECIAL: begin
                dest = instr[15:11];
                case (fn)
                    mips_pkg::FN_ADDU: res = a + b;
                    mips_pkg::FN_SUBU: res = a - b;
                    mips_pkg::FN_AND:  res = a & b;
                    mips_pkg::FN_OR:   res = a | b;
                    mips_pkg::FN_XOR:  res = a ^ b;
                    mips_pkg::FN_NOR:  res = ~(a | b);
                    mips_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    mips_pkg::FN_SLL:  res = b << instr[10:6];
                    mips_pkg::FN_SRL:  res = b >> instr[10:6];
                    default:           legal = 1'b0;
                endcase
            end
            mips_pkg::OP_ADDIU: res = a + simm;
            mips_pkg::OP_SLTI:  res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            mips_pkg::OP_ANDI:  res = a & zimm;
            mips_pkg::OP_ORI:   res = a | zimm;
            mips_pkg::OP_XORI:  res = a ^ zimm;
            mips_pkg::OP_LUI:   res = {instr[15:0], 16'h0000};
            default:            legal = 1'b0;
        endcase
        e.is_illegal = !legal;
        e.dir        = dest;
        e.data       = res;
        e.due        = 0;
        // r0 target is silent
        // illegal leaves state alone
        has_out = !legal || (dest != 5'd0);
        if (legal && dest != 5'd0) begin
            model_regs[dest] = res;
        end
    endtask

    task automatic debug_sweep();
        for (int a = 0; a < `MIPS_NREGS; a++) begin
            @(posedge i_clk);
            i_tx_dir_debug <= 5'(a);
            @(negedge i_clk);
            check_reg(5'(a), o_data_tx_debug, model_regs[a]);
        end
        @(posedge i_clk);
        i_tx_dir_debug <= '0;
    endtask

    // output monitor sampled mid-cycle
    always @(negedge i_clk) begin : monitor
        expect_t e;
        ncyc = ncyc + 1;
        if (!i_rst) begin
            if (o_wb_valid || o_illegal) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected output at %0t with nothing outstanding", $time);
                    seq_errs++;
                end else begin
                    e = exp_q.pop_front();
                    if (e.due != ncyc) begin
                        $display("Mismatch at %0t: result at cycle %0d, expected at cycle %0d",
                                 $time, ncyc, e.due);
                        seq_errs++;
                    end
                    check_illegal(o_illegal, e.is_illegal);
                    if (!e.is_illegal) begin
                        check_wb(o_wb_dir, o_wb_data, e.dir, e.data);
                    end else if (o_wb_valid) begin
                        $display("Mismatch at %0t: writeback strobe on an illegal instruction",
                                 $time);
                        ill_errs++;
                    end
                end
            end else if (exp_q.size() != 0 && exp_q[0].due <= ncyc) begin
                $display("no output at %0t for a result due at cycle %0d", $time, exp_q[0].due);
                seq_errs++;
                void'(exp_q.pop_front());
            end
            // r0 must read zero whenever the debug port points at it
            if (i_tx_dir_debug == '0) begin
                check_reg('0, o_data_tx_debug, '0);
            end
        end
    end

    initial begin : main_seq
        logic [31:0] instr;
        logic        has_out;
        expect_t     e;
        int          gap;
        int          waited;
        logic        timed_out;
        void'($urandom(SEED));
        ncyc           = 0;
        wb_errs        = 0;
        ill_errs       = 0;
        reg_errs       = 0;
        seq_errs       = 0;
        timed_out      = 1'b0;
        i_rst          = 1'b1;
        i_step         = 1'b0;
        i_instruction  = '0;
        i_tx_dir_debug = '0;
        for (int i = 0; i < `MIPS_NREGS; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge i_clk);
        i_rst <= 1'b0;

        // fresh file must read all zero
        debug_sweep();

        for (int n = 0; n < NUM_INSTR; n++) begin
            // half the steps back to back
            gap = ($urandom_range(0, 1) == 0) ? 0 : $urandom_range(1, 3);
            repeat (gap) begin
                @(posedge i_clk);
                i_step <= 1'b0;
            end
            @(posedge i_clk);
            instr = rand_instr();
            i_step        <= 1'b1;
            i_instruction <= instr;
            model_step(instr, has_out, e);
            if (has_out) begin
                e.due = ncyc + 3;
                exp_q.push_back(e);
            end
        end
        @(posedge i_clk);
        i_step <= 1'b0;

        // drain outstanding results
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge i_clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout with %0d results still outstanding", exp_q.size());
            timed_out = 1'b1;
            seq_errs++;
        end else begin
            // a few idle cycles to catch stray strobes
            repeat (4) @(posedge i_clk);
            debug_sweep();
        end

        $display("errors: wb %0d, illegal %0d, reg %0d, sequence %0d, timeout %0d",
                 wb_errs, ill_errs, reg_errs, seq_errs, timed_out);
        if (wb_errs + ill_errs + reg_errs + seq_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/mips_core_top.sv
`default_nettype none

`include "mips_consts.svh"

module mips_core_top (
    input  wire                    i_clk,
    input  wire                    i_rst,
    // one instruction per strobe, no back-pressure
    input  wire                    i_step,
    input  wire [`MIPS_NB-1:0]     i_instruction,
    // debug register read
    input  wire [`MIPS_REGS-1:0]   i_tx_dir_debug,
    output logic [`MIPS_NB-1:0]    o_data_tx_debug,
    // writeback, two cycles after the step
    output logic                   o_wb_valid,
    output logic [`MIPS_REGS-1:0]  o_wb_dir,
    output logic [`MIPS_NB-1:0]    o_wb_data,
    output logic                   o_illegal
);

    // writeback loop back into decode
    logic                  wb_valid;
    logic [`MIPS_REGS-1:0] wb_dir;
    logic [`MIPS_NB-1:0]   wb_data;

    id_ex_if u_id_ex ();

    id_stage u_id_stage (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_step          (i_step),
        .i_instruction   (i_instruction),
        .i_tx_dir_debug  (i_tx_dir_debug),
        .i_wb_valid      (wb_valid),
        .i_wb_dir        (wb_dir),
        .i_wb_data       (wb_data),
        .o_data_tx_debug (o_data_tx_debug),
        .o_id_ex         (u_id_ex.producer)
    );

    ex_stage u_ex_stage (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_id_ex    (u_id_ex.consumer),
        .o_wb_valid (wb_valid),
        .o_wb_dir   (wb_dir),
        .o_wb_data  (wb_data),
        .o_illegal  (o_illegal)
    );

    // same writeback seen by the outside
    assign o_wb_valid = wb_valid;
    assign o_wb_dir   = wb_dir;
    assign o_wb_data  = wb_data;

endmodule

`default_nettype wire

// File: logic/ex_stage.sv
`default_nettype none

`include "mips_consts.svh"

module ex_stage (
    input  wire                    i_clk,
    input  wire                    i_rst,
    id_ex_if.consumer              i_id_ex,
    output logic                   o_wb_valid,
    output logic [`MIPS_REGS-1:0]  o_wb_dir,
    output logic [`MIPS_NB-1:0]    o_wb_data,
    output logic                   o_illegal
);

    logic [`MIPS_NB-1:0] op_a;
    logic [`MIPS_NB-1:0] op_b;
    logic [`MIPS_NB-1:0] alu_res;
    logic                slt_bit;

    assign op_a = i_id_ex.data_rs;
    // operand b, immediate for I-type
    assign op_b = i_id_ex.alu_src ? i_id_ex.imm_ext : i_id_ex.data_rt;

    // signed less-than, shared by SLT and SLTI
    assign slt_bit = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (i_id_ex.alu_op)
            mips_pkg::ALU_ADD:      alu_res = op_a + op_b;
            mips_pkg::ALU_SUB:      alu_res = op_a - op_b;
            mips_pkg::ALU_AND:      alu_res = op_a & op_b;
            mips_pkg::ALU_OR:       alu_res = op_a | op_b;
            mips_pkg::ALU_XOR:      alu_res = op_a ^ op_b;
            mips_pkg::ALU_NOR:      alu_res = ~(op_a | op_b);
            mips_pkg::ALU_SLT:      alu_res = {{(`MIPS_NB-1){1'b0}}, slt_bit};
            // shifts take rt and shamt, never the immediate
            mips_pkg::ALU_SLL:      alu_res = i_id_ex.data_rt << i_id_ex.shamt;
            mips_pkg::ALU_SRL:      alu_res = i_id_ex.data_rt >> i_id_ex.shamt;
            // lui, already shifted in decode
            mips_pkg::ALU_PASS_IMM: alu_res = i_id_ex.imm_ext;
            default:                alu_res = '0;
        endcase
    end

    // strobes, one cycle each
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_valid <= 1'b0;
            o_illegal  <= 1'b0;
        end else begin
            o_wb_valid <= i_id_ex.valid && i_id_ex.reg_write;
            o_illegal  <= i_id_ex.valid && i_id_ex.illegal;
        end
    end

    // result payload
    always_ff @(posedge i_clk) begin
        if (i_id_ex.valid) begin
            o_wb_dir  <= i_id_ex.dest;
            o_wb_data <= alu_res;
        end
    end

    // control unit drops reg_write on any illegal decode
    a_wb_xor_illegal : assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(o_wb_valid && o_illegal)
    );

endmodule

`default_nettype wire

// File: logic/id_stage.sv
`default_nettype none

`include "mips_consts.svh"

// decode to execute bundle
// data_rs and data_rt are read during the valid cycle
interface id_ex_if;
    logic                     valid;
    mips_pkg::alu_op_e        alu_op;
    logic                     alu_src;
    logic [`MIPS_REGS-1:0]    shamt;
    logic [`MIPS_NB-1:0]      data_rs;
    logic [`MIPS_NB-1:0]      data_rt;
    logic [`MIPS_NB-1:0]      imm_ext;
    logic [`MIPS_REGS-1:0]    dest;
    logic                     reg_write;
    logic                     illegal;

    modport producer (
        output valid, alu_op, alu_src, shamt, data_rs, data_rt,
               imm_ext, dest, reg_write, illegal
    );
    modport consumer (
        input  valid, alu_op, alu_src, shamt, data_rs, data_rt,
               imm_ext, dest, reg_write, illegal
    );
endinterface

module id_stage (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire                    i_step,
    input  wire [`MIPS_NB-1:0]     i_instruction,
    input  wire [`MIPS_REGS-1:0]   i_tx_dir_debug,
    input  wire                    i_wb_valid,
    input  wire [`MIPS_REGS-1:0]   i_wb_dir,
    input  wire [`MIPS_NB-1:0]     i_wb_data,
    output logic [`MIPS_NB-1:0]    o_data_tx_debug,
    id_ex_if.producer              o_id_ex
);

    mips_pkg::opcode_e          opcode;
    mips_pkg::funct_e           funct;
    logic [`MIPS_REGS-1:0]      rs, rt, rd, shamt, dest;
    logic [`MIPS_INBITS-1:0]    imm;
    logic [`MIPS_NB-1:0]        imm_ext;
    mips_pkg::alu_op_e          cu_alu_op;
    mips_pkg::ext_mode_e        cu_ext_mode;
    logic                       cu_alu_src, cu_reg_dst, cu_reg_write, cu_illegal;
    // source addresses held for the late register read
    logic [`MIPS_REGS-1:0]      rs_q, rt_q;
    logic [`MIPS_NB-1:0]        rf_rs, rf_rt;

    // field split in the standard mips layout
    assign opcode = mips_pkg::opcode_e'(i_instruction[31 -: `MIPS_CTRLNB]);
    assign rs     = i_instruction[25 -: `MIPS_REGS];
    assign rt     = i_instruction[20 -: `MIPS_REGS];
    assign rd     = i_instruction[15 -: `MIPS_REGS];
    assign shamt  = i_instruction[10 -: `MIPS_REGS];
    assign imm    = i_instruction[`MIPS_INBITS-1:0];
    assign funct  = mips_pkg::funct_e'(i_instruction[`MIPS_CTRLNB-1:0]);

    control_unit u_control_unit (
        .i_opcode    (opcode),
        .i_funct     (funct),
        .o_alu_op    (cu_alu_op),
        .o_alu_src   (cu_alu_src),
        .o_ext_mode  (cu_ext_mode),
        .o_reg_dst   (cu_reg_dst),
        .o_reg_write (cu_reg_write),
        .o_illegal   (cu_illegal)
    );

    always_comb begin
        case (cu_ext_mode)
            mips_pkg::EXT_SIGN:  imm_ext = {{(`MIPS_NB-`MIPS_INBITS){imm[`MIPS_INBITS-1]}}, imm};
            mips_pkg::EXT_ZERO:  imm_ext = {{(`MIPS_NB-`MIPS_INBITS){1'b0}}, imm};
            mips_pkg::EXT_UPPER: imm_ext = {imm, {(`MIPS_NB-`MIPS_INBITS){1'b0}}};
            default:             imm_ext = '0;
        endcase
    end

    // rd for R-type, rt for I-type
    assign dest = cu_reg_dst ? rd : rt;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex.valid <= 1'b0;
        end else begin
            o_id_ex.valid <= i_step;
        end
    end

    // payload loads only on a step
    always_ff @(posedge i_clk) begin
        if (i_step) begin
            o_id_ex.alu_op    <= cu_alu_op;
            o_id_ex.alu_src   <= cu_alu_src;
            o_id_ex.shamt     <= shamt;
            o_id_ex.imm_ext   <= imm_ext;
            o_id_ex.dest      <= dest;
            // writes to r0 are dropped here
            o_id_ex.reg_write <= cu_reg_write && (dest != '0);
            o_id_ex.illegal   <= cu_illegal;
            rs_q              <= rs;
            rt_q              <= rt;
        end
    end

    reg_file u_reg_file (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_dir_rs        (rs_q),
        .i_dir_rt        (rt_q),
        .i_tx_dir_debug  (i_tx_dir_debug),
        .i_wb_valid      (i_wb_valid),
        .i_wb_dir        (i_wb_dir),
        .i_wb_data       (i_wb_data),
        .o_data_rs       (rf_rs),
        .o_data_rt       (rf_rt),
        .o_data_tx_debug (o_data_tx_debug)
    );

    // pending writeback lands one edge late so bypass it
    // the older write is already in the file by now
    assign o_id_ex.data_rs = (i_wb_valid && (i_wb_dir == rs_q)) ? i_wb_data : rf_rs;
    assign o_id_ex.data_rt = (i_wb_valid && (i_wb_dir == rt_q)) ? i_wb_data : rf_rt;

    // lui passes imm_ext straight through and needs the upper-half form
    a_pass_imm_upper : assert property (
        @(posedge i_clk) disable iff (i_rst)
        (i_step && (cu_alu_op == mips_pkg::ALU_PASS_IMM))
            |-> (cu_ext_mode == mips_pkg::EXT_UPPER)
    );

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`default_nettype none

`include "mips_consts.svh"

module reg_file (
    input  wire                    i_clk,
    input  wire                    i_rst,
    input  wire [`MIPS_REGS-1:0]   i_dir_rs,
    input  wire [`MIPS_REGS-1:0]   i_dir_rt,
    input  wire [`MIPS_REGS-1:0]   i_tx_dir_debug,
    input  wire                    i_wb_valid,
    input  wire [`MIPS_REGS-1:0]   i_wb_dir,
    input  wire [`MIPS_NB-1:0]     i_wb_data,
    output logic [`MIPS_NB-1:0]    o_data_rs,
    output logic [`MIPS_NB-1:0]    o_data_rt,
    output logic [`MIPS_NB-1:0]    o_data_tx_debug
);

    logic [`MIPS_NB-1:0] regs [`MIPS_NREGS];

    // whole file clears on reset, every register reads zero after
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 0; i < `MIPS_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_valid && (i_wb_dir != '0)) begin
            regs[i_wb_dir] <= i_wb_data;
        end
    end

    // async reads
    // r0 forced to zero regardless of array content
    assign o_data_rs       = (i_dir_rs == '0) ? '0 : regs[i_dir_rs];
    assign o_data_rt       = (i_dir_rt == '0) ? '0 : regs[i_dir_rt];
    // debug sees stored values only, no forwarding
    assign o_data_tx_debug = (i_tx_dir_debug == '0) ? '0 : regs[i_tx_dir_debug];

    // execute stage never strobes a write to r0
    // decode clears reg_write for a zero destination
    a_no_wb_r0 : assert property (
        @(posedge i_clk) disable iff (i_rst)
        i_wb_valid |-> (i_wb_dir != '0)
    );

endmodule

`default_nettype wire

// File: logic/control_unit.sv
`default_nettype none

`include "mips_consts.svh"

module control_unit (
    input  wire mips_pkg::opcode_e   i_opcode,
    input  wire mips_pkg::funct_e    i_funct,
    output mips_pkg::alu_op_e        o_alu_op,
    output logic                     o_alu_src,
    output mips_pkg::ext_mode_e      o_ext_mode,
    output logic                     o_reg_dst,
    output logic                     o_reg_write,
    output logic                     o_illegal
);

    always_comb begin
        // defaults match an R-type register-register op
        o_alu_op    = mips_pkg::ALU_ADD;
        o_alu_src   = 1'b0;
        o_ext_mode  = mips_pkg::EXT_SIGN;
        o_reg_dst   = 1'b1;
        o_reg_write = 1'b1;
        o_illegal   = 1'b0;

        case (i_opcode)
            mips_pkg::OP_SPECIAL: begin
                // rd destination, operand b from rt
                case (i_funct)
                    mips_pkg::FN_ADDU: o_alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: o_alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  o_alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   o_alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  o_alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_NOR:  o_alu_op = mips_pkg::ALU_NOR;
                    mips_pkg::FN_SLT:  o_alu_op = mips_pkg::ALU_SLT;
                    // shifts use shamt, rs is ignored
                    mips_pkg::FN_SLL:  o_alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  o_alu_op = mips_pkg::ALU_SRL;
                    default: begin
                        // unknown funct, no write
                        o_reg_write = 1'b0;
                        o_illegal   = 1'b1;
                    end
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                o_alu_op  = mips_pkg::ALU_ADD;
                o_alu_src = 1'b1;
                o_reg_dst = 1'b0;
            end
            mips_pkg::OP_SLTI: begin
                // signed compare against the sign-extended imm
                o_alu_op  = mips_pkg::ALU_SLT;
                o_alu_src = 1'b1;
                o_reg_dst = 1'b0;
            end
            mips_pkg::OP_ANDI: begin
                // logical immediates are zero extended
                o_alu_op   = mips_pkg::ALU_AND;
                o_alu_src  = 1'b1;
                o_ext_mode = mips_pkg::EXT_ZERO;
                o_reg_dst  = 1'b0;
            end
            mips_pkg::OP_ORI: begin
                o_alu_op   = mips_pkg::ALU_OR;
                o_alu_src  = 1'b1;
                o_ext_mode = mips_pkg::EXT_ZERO;
                o_reg_dst  = 1'b0;
            end
            mips_pkg::OP_XORI: begin
                o_alu_op   = mips_pkg::ALU_XOR;
                o_alu_src  = 1'b1;
                o_ext_mode = mips_pkg::EXT_ZERO;
                o_reg_dst  = 1'b0;
            end
            mips_pkg::OP_LUI: begin
                // imm lands in the upper half, alu just passes it
                o_alu_op   = mips_pkg::ALU_PASS_IMM;
                o_alu_src  = 1'b1;
                o_ext_mode = mips_pkg::EXT_UPPER;
                o_reg_dst  = 1'b0;
            end
            default: begin
                o_reg_write = 1'b0;
                o_illegal   = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/mips_pkg.sv
`default_nettype none

`include "mips_consts.svh"

package mips_pkg;

    // primary opcode, bits 31:26 of the word
    // SPECIAL means look at funct
    typedef enum logic [`MIPS_CTRLNB-1:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // funct field, bits 5:0, only meaningful under SPECIAL
    typedef enum logic [`MIPS_CTRLNB-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a
    } funct_e;

    // operation selected for the execute stage
    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_AND      = 4'd2,
        ALU_OR       = 4'd3,
        ALU_XOR      = 4'd4,
        ALU_NOR      = 4'd5,
        ALU_SLT      = 4'd6,
        ALU_SLL      = 4'd7,
        ALU_SRL      = 4'd8,
        ALU_PASS_IMM = 4'd9
    } alu_op_e;

    // how the 16-bit immediate grows to the data width
    typedef enum logic [1:0] {
        EXT_SIGN  = 2'd0,
        EXT_ZERO  = 2'd1,
        EXT_UPPER = 2'd2
    } ext_mode_e;

endpackage

`default_nettype wire

// File: logic/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// datapath and instruction word width
`define MIPS_NB 32

// bits of a register address (rs, rt, rd, shamt)
`define MIPS_REGS 5

// immediate field of an I-type word
`define MIPS_INBITS 16

// opcode and funct fields share this width
`define MIPS_CTRLNB 6

// register file depth
`define MIPS_NREGS 32

`endif
